//--- sources.f
hdl/dac_cfg_pkg.sv
hdl/dac_data_pkg.sv
hdl/dac_chan_regs.sv
hdl/dac_tone_gen.sv
hdl/dac_source_mux.sv
hdl/dac_iq_correct.sv
hdl/dac_tx_channel.sv
tests/dac_tx_channel_assertions.sv
tests/dac_tx_channel_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dac channel testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dac_tx_channel_tb \
  -f sources.f -o sim_dac_tx_channel > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_dac_tx_channel > sim.log 2>&1
grep -q "^>>> PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- tests/dac_tx_channel_tb.sv
`timescale 1ns/1ps

module dac_tx_channel_tb;

  localparam logic [31:0] CHANNEL_ID = 32'h5;
  localparam int          Q_OR_I_N   = 0;

  // rough cycle budget of all tests, used by the watchdog
  localparam int  PLANNED_CYCLES = 1500;
  localparam real WATCHDOG_NS    = PLANNED_CYCLES * 100.0 * 2.0 + 10000.0;

  logic                       dac_clk;
  logic                       reset;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  dac_cfg_pkg::apb_addr_t     paddr;
  logic [31:0]                pwdata;
  logic [31:0]                prdata;
  dac_data_pkg::sample_pair_t dma_data;
  logic                       dma_ready;
  dac_data_pkg::sample_pair_t iq_partner;
  dac_data_pkg::sample_pair_t pre_iq;
  dac_data_pkg::sample_pair_t dac_data;

  // reference model state
  dac_cfg_pkg::dac_chan_cfg_t m_cfg;
  logic                       m_sync;
  logic [15:0]                m_ph0;
  logic [15:0]                m_ph1;
  logic [15:0]                m_step;
  dac_data_pkg::sample_pair_t m_tone;
  dac_data_pkg::sample_pair_t m_pre;
  logic                       m_ready;
  longint                     m_sum [2];
  dac_data_pkg::sample_pair_t m_dac;

  string cur_test;

  dac_tx_channel #(
    .CHANNEL_ID (CHANNEL_ID),
    .Q_OR_I_N   (Q_OR_I_N)
  ) i_dac_tx_channel (
    .dac_clk    (dac_clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .dma_data   (dma_data),
    .dma_ready  (dma_ready),
    .iq_partner (iq_partner),
    .pre_iq     (pre_iq),
    .dac_data   (dac_data)
  );

  initial begin
    dac_clk = 1'b0;
    forever #50 dac_clk = ~dac_clk;
  end

  initial begin
    #(WATCHDOG_NS * 1ns);
    $display("timeout: tests did not finish");
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  // **********************************************************************
  // compare tasks
  // **********************************************************************

  task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "register mismatch");
    end
  endtask

  task automatic check_pair(input string name, input dac_data_pkg::sample_pair_t exp,
                            input dac_data_pkg::sample_pair_t act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "sample pair mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "flag mismatch");
    end
  endtask

  // **********************************************************************
  // reference model
  // **********************************************************************

  // triangle wave then Q1.15 gain, kept to 16 bits
  function automatic dac_data_pkg::sample_t tri_scaled(input logic [15:0] phase,
                                                       input logic [15:0] scale);
    int     v;
    longint p;
    if (phase[15]) begin
      v = 32767 - 2 * int'(phase[14:0]);
    end else begin
      v = 2 * int'(phase[14:0]) - 32768;
    end
    p = (longint'(v) * longint'(scale)) >>> 15;
    return dac_data_pkg::sample_t'(p[15:0]);
  endfunction

  function automatic longint iq_terms(input dac_data_pkg::sample_t own,
                                      input dac_data_pkg::sample_t partner,
                                      input dac_cfg_pkg::dac_chan_cfg_t c);
    longint own_t;
    longint par_t;
    if (!c.iq_enable) begin
      return longint'(own) * 16384;
    end
    own_t = longint'(own) * longint'(c.iq_coeff1);
    par_t = longint'(partner) * longint'(c.iq_coeff2);
    return (Q_OR_I_N == 1) ? own_t - par_t : own_t + par_t;
  endfunction

  function automatic dac_data_pkg::sample_t clip(input longint sum);
    longint s;
    s = sum >>> 14;
    if (s > 32767) begin
      return 16'sh7fff;
    end else if (s < -32768) begin
      return 16'sh8000;
    end
    return dac_data_pkg::sample_t'(s[15:0]);
  endfunction

  function automatic logic [31:0] model_read(input dac_cfg_pkg::apb_addr_t addr);
    case (addr)
      dac_cfg_pkg::REG_CTRL:       return {27'h0, m_cfg.iq_enable, 2'b00, m_cfg.source};
      dac_cfg_pkg::REG_TONE_INIT:  return {16'h0, m_cfg.tone_init};
      dac_cfg_pkg::REG_TONE_INCR:  return {16'h0, m_cfg.tone_incr};
      dac_cfg_pkg::REG_TONE_SCALE: return {16'h0, m_cfg.tone_scale};
      dac_cfg_pkg::REG_PATTERN:    return m_cfg.pattern;
      dac_cfg_pkg::REG_IQ_COEFF1:  return {16'h0, m_cfg.iq_coeff1};
      dac_cfg_pkg::REG_IQ_COEFF2:  return {16'h0, m_cfg.iq_coeff2};
      dac_cfg_pkg::REG_CHAN_ID:    return CHANNEL_ID;
      default:                     return 32'h0;
    endcase
  endfunction

  task automatic model_write(input dac_cfg_pkg::apb_addr_t addr, input logic [31:0] data);
    case (addr)
      dac_cfg_pkg::REG_CTRL: begin
        m_cfg.source    = dac_cfg_pkg::dac_src_e'(data[1:0]);
        m_cfg.iq_enable = data[4];
        m_sync          = data[8];
      end
      dac_cfg_pkg::REG_TONE_INIT:  m_cfg.tone_init  = data[15:0];
      dac_cfg_pkg::REG_TONE_INCR:  m_cfg.tone_incr  = data[15:0];
      dac_cfg_pkg::REG_TONE_SCALE: m_cfg.tone_scale = data[15:0];
      dac_cfg_pkg::REG_PATTERN:    m_cfg.pattern    = data;
      dac_cfg_pkg::REG_IQ_COEFF1:  m_cfg.iq_coeff1  = data[15:0];
      dac_cfg_pkg::REG_IQ_COEFF2:  m_cfg.iq_coeff2  = data[15:0];
      default: begin
      end
    endcase
  endtask

  // one clock edge, later pipeline stages first so each sees old state
  task automatic model_edge();
    if (reset) begin
      m_cfg   = '0;
      m_sync  = 1'b0;
      m_ph0   = '0;
      m_ph1   = '0;
      m_step  = '0;
      m_tone  = '0;
      m_pre   = '0;
      m_ready = 1'b0;
      m_sum[0] = 0;
      m_sum[1] = 0;
      m_dac   = '0;
    end else begin
      m_dac.lane0 = clip(m_sum[0]);
      m_dac.lane1 = clip(m_sum[1]);
      m_sum[0] = iq_terms(m_pre.lane0, iq_partner.lane0, m_cfg);
      m_sum[1] = iq_terms(m_pre.lane1, iq_partner.lane1, m_cfg);
      m_ready = (m_cfg.source == dac_cfg_pkg::SRC_DMA);
      case (m_cfg.source)
        dac_cfg_pkg::SRC_TONE:    m_pre = m_tone;
        dac_cfg_pkg::SRC_PATTERN: m_pre = dac_data_pkg::sample_pair_t'(m_cfg.pattern);
        dac_cfg_pkg::SRC_DMA:     m_pre = dma_data;
        default:                  m_pre = '0;
      endcase
      if (m_sync) begin
        m_ph0  = m_cfg.tone_init;
        m_ph1  = m_cfg.tone_init + m_cfg.tone_incr;
        m_step = m_cfg.tone_incr + m_cfg.tone_incr;
        m_tone = '0;
      end else begin
        m_tone.lane0 = tri_scaled(m_ph0, m_cfg.tone_scale);
        m_tone.lane1 = tri_scaled(m_ph1, m_cfg.tone_scale);
        m_ph0 = m_ph0 + m_step;
        m_ph1 = m_ph1 + m_step;
      end
      m_sync = 1'b0;
      if (psel && penable && pwrite) begin
        model_write(paddr, pwdata);
      end
    end
  endtask

  // **********************************************************************
  // stimulus
  // **********************************************************************

  // advance one clock, check every output, then drive fresh stream data
  task automatic tick();
    @(posedge dac_clk);
    #1;
    model_edge();
    check_pair({cur_test, " dac_data"}, m_dac, dac_data);
    check_pair({cur_test, " pre_iq"}, m_pre, pre_iq);
    check_flag({cur_test, " dma_ready"}, m_ready, dma_ready);
    dma_data   = dac_data_pkg::sample_pair_t'($urandom());
    iq_partner = dac_data_pkg::sample_pair_t'($urandom());
  endtask

  task automatic apb_write(input dac_cfg_pkg::apb_addr_t addr, input logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    tick();
    penable = 1'b1;
    tick();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read_check(input dac_cfg_pkg::apb_addr_t addr);
    logic [31:0] data;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    tick();
    penable = 1'b1;
    #1;
    data = prdata;
    check_reg({cur_test, " read"}, model_read(addr), data);
    tick();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_all();
    for (int a = 0; a < 8; a++) begin
      apb_read_check(dac_cfg_pkg::apb_addr_t'(a * 4));
    end
    apb_read_check(8'h24);
    apb_read_check(8'hfc);
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  // **********************************************************************
  // test sequence
  // **********************************************************************

  initial begin
    dac_data_pkg::sample_pair_t sent [$];
    logic [15:0]                c1 [3];
    logic [15:0]                c2 [3];
    void'($urandom(1));
    cur_test    = "reset";
    reset      = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    dma_data   = '0;
    iq_partner = '0;
    idle(4);
    reset = 1'b0;
    tick();

    cur_test = "reset_state";
    check_flag({cur_test, " dma_ready"}, 1'b0, dma_ready);
    check_pair({cur_test, " dac_data"}, '0, dac_data);
    read_all();

    cur_test = "reg_readback";
    apb_write(dac_cfg_pkg::REG_CTRL, $urandom() & 32'h0000_0013);
    for (int a = 1; a < 8; a++) begin
      apb_write(dac_cfg_pkg::apb_addr_t'(a * 4), $urandom());
    end
    apb_write(8'h24, $urandom());
    read_all();

    cur_test = "zero_then_pattern";
    apb_write(dac_cfg_pkg::REG_CTRL, 32'h3);
    idle(4);
    check_pair({cur_test, " zero"}, '0, dac_data);
    apb_write(dac_cfg_pkg::REG_CTRL, 32'h1);
    idle(4);
    check_pair({cur_test, " pattern"}, dac_data_pkg::sample_pair_t'(m_cfg.pattern), dac_data);

    cur_test = "dma_stream";
    apb_write(dac_cfg_pkg::REG_CTRL, 32'h2);
    idle(2);
    check_flag({cur_test, " ready"}, 1'b1, dma_ready);
    for (int i = 0; i < 202; i++) begin
      sent.push_back(dma_data);
      tick();
      if (sent.size() == 3) begin
        check_pair({cur_test, " passthrough"}, sent.pop_front(), dac_data);
      end
    end

    cur_test = "tone";
    apb_write(dac_cfg_pkg::REG_TONE_INIT, $urandom());
    apb_write(dac_cfg_pkg::REG_TONE_INCR, $urandom());
    apb_write(dac_cfg_pkg::REG_TONE_SCALE, $urandom());
    apb_write(dac_cfg_pkg::REG_CTRL, 32'h100);
    idle(300);

    cur_test = "iq_correct";
    c1[0] = 16'($urandom());
    c2[0] = 16'($urandom());
    // largest and most negative gains push the sum past both limits
    c1[1] = 16'h7fff;
    c2[1] = 16'h7fff;
    c1[2] = 16'h8000;
    c2[2] = 16'h8000;
    for (int k = 0; k < 3; k++) begin
      apb_write(dac_cfg_pkg::REG_IQ_COEFF1, {16'h0, c1[k]});
      apb_write(dac_cfg_pkg::REG_IQ_COEFF2, {16'h0, c2[k]});
      apb_write(dac_cfg_pkg::REG_CTRL, 32'h12);
      idle(200);
    end

    if (i_dac_tx_channel.i_dac_tx_channel_assertions.fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display(">>> FAIL");
      $fatal(1, "assertions failed");
    end
  end

endmodule

//--- tests/dac_tx_channel_assertions.sv
`timescale 1ns/1ps

module dac_tx_channel_assertions (
  input logic                   dac_clk,
  input logic                   reset,
  input logic                   psel,
  input logic                   penable,
  input logic                   pwrite,
  input dac_cfg_pkg::apb_addr_t paddr,
  input logic                   dma_ready
);

  logic        ctrl_wr;
  // failed assertions so far
  int unsigned fail_count = 0;

  assign ctrl_wr = psel && penable && pwrite && (paddr == dac_cfg_pkg::REG_CTRL);

  assert property (@(posedge dac_clk) reset |=> !dma_ready)
    else begin
      fail_count++;
      $error("dma_ready high in the cycle after reset");
    end

  assert property (@(posedge dac_clk) disable iff (reset) penable |-> psel)
    else begin
      fail_count++;
      $error("penable high without psel");
    end

  // dma source only leaves after a ctrl write, seen two edges later
  assert property (@(posedge dac_clk) disable iff (reset) $fell(dma_ready) |-> $past(ctrl_wr, 2))
    else begin
      fail_count++;
      $error("dma_ready dropped without a ctrl write");
    end

endmodule

bind dac_tx_channel dac_tx_channel_assertions i_dac_tx_channel_assertions (
  .dac_clk   (dac_clk),
  .reset     (reset),
  .psel      (psel),
  .penable   (penable),
  .pwrite    (pwrite),
  .paddr     (paddr),
  .dma_ready (dma_ready)
);

//--- hdl/dac_tx_channel.sv
`timescale 1ns/1ps

module dac_tx_channel #(
  parameter logic [31:0] CHANNEL_ID = 32'h0,
  parameter int          Q_OR_I_N   = 0
) (
  input  logic                       dac_clk,
  input  logic                       reset,

  // apb
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  dac_cfg_pkg::apb_addr_t     paddr,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,

  // dma stream
  input  dac_data_pkg::sample_pair_t dma_data,
  output logic                       dma_ready,

  // partner channel exchange
  input  dac_data_pkg::sample_pair_t iq_partner,
  output dac_data_pkg::sample_pair_t pre_iq,

  // converter
  output dac_data_pkg::sample_pair_t dac_data
);

  dac_cfg_pkg::dac_chan_cfg_t cfg;
  logic                       tone_sync;
  dac_data_pkg::sample_pair_t tone;

  dac_chan_regs #(
    .CHANNEL_ID (CHANNEL_ID)
  ) i_dac_chan_regs (
    .dac_clk   (dac_clk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .cfg       (cfg),
    .tone_sync (tone_sync)
  );

  dac_tone_gen i_dac_tone_gen (
    .dac_clk   (dac_clk),
    .reset     (reset),
    .cfg       (cfg),
    .tone_sync (tone_sync),
    .tone      (tone)
  );

  dac_source_mux i_dac_source_mux (
    .dac_clk   (dac_clk),
    .reset     (reset),
    .cfg       (cfg),
    .tone      (tone),
    .dma_data  (dma_data),
    .pre_iq    (pre_iq),
    .dma_ready (dma_ready)
  );

  dac_iq_correct #(
    .Q_OR_I_N (Q_OR_I_N)
  ) i_dac_iq_correct (
    .dac_clk    (dac_clk),
    .reset      (reset),
    .cfg        (cfg),
    .pre_iq     (pre_iq),
    .iq_partner (iq_partner),
    .dac_data   (dac_data)
  );

endmodule

//--- hdl/dac_iq_correct.sv
`timescale 1ns/1ps

module dac_iq_correct #(
  // 0 for the I channel, 1 for the Q channel
  parameter int Q_OR_I_N = 0
) (
  input  logic                       dac_clk,
  input  logic                       reset,
  input  dac_cfg_pkg::dac_chan_cfg_t cfg,
  input  dac_data_pkg::sample_pair_t pre_iq,
  input  dac_data_pkg::sample_pair_t iq_partner,
  output dac_data_pkg::sample_pair_t dac_data
);

  localparam logic signed [32:0] SAT_MAX = 33'sd32767;
  localparam logic signed [32:0] SAT_MIN = -33'sd32768;

  dac_data_pkg::sample_t in_lane      [2];
  dac_data_pkg::sample_t partner_lane [2];

  // stage 1 product terms, partner term already signed for I or Q
  logic signed [32:0] term_own     [2];
  logic signed [32:0] term_partner [2];
  logic signed [32:0] lane_sum     [2];
  logic signed [32:0] lane_shift   [2];

  function automatic dac_data_pkg::sample_t saturate(input logic signed [32:0] value);
    if (value > SAT_MAX) begin
      return 16'sh7fff;
    end else if (value < SAT_MIN) begin
      return 16'sh8000;
    end
    return value[15:0];
  endfunction

  assign in_lane[0]      = pre_iq.lane0;
  assign in_lane[1]      = pre_iq.lane1;
  assign partner_lane[0] = iq_partner.lane0;
  assign partner_lane[1] = iq_partner.lane1;

  // **********************************************************************
  // stage 1, products
  // **********************************************************************

  always_ff @(posedge dac_clk) begin
    if (reset) begin
      for (int i = 0; i < 2; i++) begin
        term_own[i]     <= '0;
        term_partner[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (cfg.iq_enable) begin
          term_own[i] <= in_lane[i] * $signed(cfg.iq_coeff1);
          if (Q_OR_I_N == 1) begin
            term_partner[i] <= -(partner_lane[i] * $signed(cfg.iq_coeff2));
          end else begin
            term_partner[i] <= partner_lane[i] * $signed(cfg.iq_coeff2);
          end
        end else begin
          // bypass as unity gain, so stage 2 returns the sample unchanged
          term_own[i]     <= 33'(in_lane[i]) <<< dac_data_pkg::COEFF_FRAC_W;
          term_partner[i] <= '0;
        end
      end
    end
  end

  // **********************************************************************
  // stage 2, sum, scale back and clip
  // **********************************************************************

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      lane_sum[i]   = term_own[i] + term_partner[i];
      lane_shift[i] = lane_sum[i] >>> dac_data_pkg::COEFF_FRAC_W;
    end
  end

  always_ff @(posedge dac_clk) begin
    if (reset) begin
      dac_data <= '0;
    end else begin
      dac_data.lane0 <= saturate(lane_shift[0]);
      dac_data.lane1 <= saturate(lane_shift[1]);
    end
  end

endmodule

//--- hdl/dac_source_mux.sv
`timescale 1ns/1ps

module dac_source_mux (
  input  logic                       dac_clk,
  input  logic                       reset,
  input  dac_cfg_pkg::dac_chan_cfg_t cfg,
  input  dac_data_pkg::sample_pair_t tone,
  input  dac_data_pkg::sample_pair_t dma_data,
  output dac_data_pkg::sample_pair_t pre_iq,
  output logic                       dma_ready
);

  // **********************************************************************
  // source select
  // **********************************************************************

  always_ff @(posedge dac_clk) begin
    if (reset) begin
      pre_iq    <= '0;
      dma_ready <= 1'b0;
    end else begin
      // dma side streams one pair per clock while selected
      dma_ready <= (cfg.source == dac_cfg_pkg::SRC_DMA);
      case (cfg.source)
        dac_cfg_pkg::SRC_TONE: begin
          pre_iq <= tone;
        end
        dac_cfg_pkg::SRC_PATTERN: begin
          pre_iq <= dac_data_pkg::sample_pair_t'(cfg.pattern);
        end
        dac_cfg_pkg::SRC_DMA: begin
          pre_iq <= dma_data;
        end
        default: begin
          pre_iq <= '0;
        end
      endcase
    end
  end

endmodule

//--- hdl/dac_tone_gen.sv
`timescale 1ns/1ps

module dac_tone_gen (
  input  logic                       dac_clk,
  input  logic                       reset,
  input  dac_cfg_pkg::dac_chan_cfg_t cfg,
  input  logic                       tone_sync,
  output dac_data_pkg::sample_pair_t tone
);

  logic [15:0] phase_0;
  logic [15:0] phase_1;
  // two samples per clock, so each lane steps by twice the increment
  logic [15:0] phase_step;

  // triangle from the phase, full scale over one phase wrap
  function automatic dac_data_pkg::sample_t tri_shape(input logic [15:0] phase);
    logic [15:0] ramp;
    ramp = {phase[14:0], 1'b0};
    if (phase[15]) begin
      return dac_data_pkg::sample_t'(16'h7fff - ramp);
    end
    return dac_data_pkg::sample_t'(ramp - 16'h8000);
  endfunction

  // amplitude scale, unsigned Q1.15 gain
  function automatic dac_data_pkg::sample_t tone_amp(input dac_data_pkg::sample_t value,
                                                     input logic [15:0] scale);
    logic signed [32:0] product;
    logic signed [32:0] shifted;
    product = value * $signed({1'b0, scale});
    shifted = product >>> dac_data_pkg::SCALE_FRAC_W;
    return shifted[15:0];
  endfunction

  always_ff @(posedge dac_clk) begin
    if (reset) begin
      phase_0    <= '0;
      phase_1    <= '0;
      phase_step <= '0;
      tone       <= '0;
    end else if (tone_sync) begin
      // restart both lanes, lane 1 one step ahead
      phase_0    <= cfg.tone_init;
      phase_1    <= cfg.tone_init + cfg.tone_incr;
      phase_step <= {cfg.tone_incr[14:0], 1'b0};
      tone       <= '0;
    end else begin
      phase_0    <= phase_0 + phase_step;
      phase_1    <= phase_1 + phase_step;
      tone.lane0 <= tone_amp(tri_shape(phase_0), cfg.tone_scale);
      tone.lane1 <= tone_amp(tri_shape(phase_1), cfg.tone_scale);
    end
  end

endmodule

//--- hdl/dac_chan_regs.sv
`timescale 1ns/1ps

module dac_chan_regs #(
  parameter logic [31:0] CHANNEL_ID = 32'h0
) (
  input  logic                       dac_clk,
  input  logic                       reset,

  // apb slave, no wait states
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  dac_cfg_pkg::apb_addr_t     paddr,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,

  output dac_cfg_pkg::dac_chan_cfg_t cfg,
  output logic                       tone_sync
);

  logic wr_en;

  // write lands at the end of the access phase
  assign wr_en = psel & penable & pwrite;

  always_ff @(posedge dac_clk) begin
    if (reset) begin
      cfg       <= '0;
      tone_sync <= 1'b0;
    end else begin
      tone_sync <= 1'b0;
      if (wr_en) begin
        case (paddr)
          dac_cfg_pkg::REG_CTRL: begin
            cfg.source    <= dac_cfg_pkg::dac_src_e'(pwdata[1:0]);
            cfg.iq_enable <= pwdata[dac_cfg_pkg::CTRL_IQ_EN_BIT];
            // strobe only, not stored
            tone_sync     <= pwdata[dac_cfg_pkg::CTRL_SYNC_BIT];
          end
          dac_cfg_pkg::REG_TONE_INIT:  cfg.tone_init  <= pwdata[15:0];
          dac_cfg_pkg::REG_TONE_INCR:  cfg.tone_incr  <= pwdata[15:0];
          dac_cfg_pkg::REG_TONE_SCALE: cfg.tone_scale <= pwdata[15:0];
          dac_cfg_pkg::REG_PATTERN:    cfg.pattern    <= pwdata;
          dac_cfg_pkg::REG_IQ_COEFF1:  cfg.iq_coeff1  <= pwdata[15:0];
          dac_cfg_pkg::REG_IQ_COEFF2:  cfg.iq_coeff2  <= pwdata[15:0];
          default: begin
          end
        endcase
      end
    end
  end

  // **********************************************************************
  // read mux
  // **********************************************************************

  always_comb begin
    prdata = '0;
    case (paddr)
      dac_cfg_pkg::REG_CTRL: begin
        prdata[1:0]                         = cfg.source;
        prdata[dac_cfg_pkg::CTRL_IQ_EN_BIT] = cfg.iq_enable;
      end
      dac_cfg_pkg::REG_TONE_INIT:  prdata = {16'h0, cfg.tone_init};
      dac_cfg_pkg::REG_TONE_INCR:  prdata = {16'h0, cfg.tone_incr};
      dac_cfg_pkg::REG_TONE_SCALE: prdata = {16'h0, cfg.tone_scale};
      dac_cfg_pkg::REG_PATTERN:    prdata = cfg.pattern;
      dac_cfg_pkg::REG_IQ_COEFF1:  prdata = {16'h0, cfg.iq_coeff1};
      dac_cfg_pkg::REG_IQ_COEFF2:  prdata = {16'h0, cfg.iq_coeff2};
      dac_cfg_pkg::REG_CHAN_ID:    prdata = CHANNEL_ID;
      // unmapped reads return zero
      default:                     prdata = '0;
    endcase
  end

endmodule

//--- hdl/dac_data_pkg.sv
package dac_data_pkg;

  // **********************************************************************
  // sample format
  // **********************************************************************

  localparam int SAMPLE_W = 16;

  // fractional bits of the tone amplitude (Q1.15)
  localparam int SCALE_FRAC_W = 15;

  // fractional bits of the iq coefficients (Q2.14)
  localparam int COEFF_FRAC_W = 14;

  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // two samples per dac_clk, lane 1 is the later one
  typedef struct packed {
    sample_t lane1;
    sample_t lane0;
  } sample_pair_t;

endpackage

//--- hdl/dac_cfg_pkg.sv
package dac_cfg_pkg;

  // **********************************************************************
  // apb register map
  // **********************************************************************

  // byte address, registers sit on 32-bit word boundaries
  typedef logic [7:0] apb_addr_t;

  localparam apb_addr_t REG_CTRL       = 8'h00;
  localparam apb_addr_t REG_TONE_INIT  = 8'h04;
  localparam apb_addr_t REG_TONE_INCR  = 8'h08;
  localparam apb_addr_t REG_TONE_SCALE = 8'h0C;
  localparam apb_addr_t REG_PATTERN    = 8'h10;
  localparam apb_addr_t REG_IQ_COEFF1  = 8'h14;
  localparam apb_addr_t REG_IQ_COEFF2  = 8'h18;
  localparam apb_addr_t REG_CHAN_ID    = 8'h1C;

  // ctrl register bit positions, source select is bits 1:0
  localparam int CTRL_IQ_EN_BIT = 4;
  localparam int CTRL_SYNC_BIT  = 8;

  // **********************************************************************
  // channel configuration
  // **********************************************************************

  typedef enum logic [1:0] {
    SRC_TONE    = 2'd0,
    SRC_PATTERN = 2'd1,
    SRC_DMA     = 2'd2,
    SRC_ZERO    = 2'd3
  } dac_src_e;

  typedef struct packed {
    dac_src_e           source;
    logic               iq_enable;
    logic [15:0]        tone_init;
    logic [15:0]        tone_incr;
    // unsigned Q1.15
    logic [15:0]        tone_scale;
    // lane 1 in the upper half
    logic [31:0]        pattern;
    // signed Q2.14
    logic signed [15:0] iq_coeff1;
    logic signed [15:0] iq_coeff2;
  } dac_chan_cfg_t;

endpackage
